/* design/cluster_bus_pkg.sv */
// cluster bus package: address map constants and target index type for the AX routing
package cluster_bus_pkg;

  // the map below is only defined for 32-bit addresses
  localparam int unsigned ADDR_WIDTH       = 32;
  localparam int unsigned LEN_WIDTH        = 8;
  localparam int unsigned CLUSTER_ID_WIDTH = 6;

  // cluster 0 sits here, every further cluster adds one stride
  localparam logic [ADDR_WIDTH-1:0] CLUSTER_ADDR_ORIGIN = 32'h1000_0000;
  // 4 MiB per cluster
  localparam int unsigned CLUSTER_ADDR_STRIDE_LOG2 = 22;

  // offsets relative to the cluster base
  localparam logic [ADDR_WIDTH-1:0] TCDM_SIZE         = 32'h0010_0000;
  localparam logic [ADDR_WIDTH-1:0] PERIPH_OFFSET     = 32'h0020_0000;
  localparam logic [ADDR_WIDTH-1:0] PERIPH_END_OFFSET = 32'h0040_0000;

  // target ports, also the bit position in the decoder target vectors
  typedef enum logic [1:0] {
    TGT_TCDM   = 2'd0,
    TGT_PERIPH = 2'd1,
    TGT_EXT    = 2'd2
  } tgt_idx_e;

  localparam int unsigned NB_TARGETS = 3;

endpackage

/* design/cluster_ax_slice.sv */
// AX slice: two-entry spill register cutting valid, data and ready paths at full rate
module cluster_ax_slice #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     arst_n_i,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  // entry a drives the output, entry b catches a beat while the output stalls
  logic     a_full_q, a_full_d;
  logic     b_full_q, b_full_d;
  payload_t a_data_q, b_data_q;
  logic     in_fire;
  logic     a_load_in, a_load_spill, b_load;

  assign ready_o = ~b_full_q;
  assign valid_o = a_full_q;
  assign data_o  = a_data_q;
  assign in_fire = valid_i & ready_o;

  always_comb begin
    a_full_d     = a_full_q;
    b_full_d     = b_full_q;
    a_load_in    = 1'b0;
    a_load_spill = 1'b0;
    b_load       = 1'b0;
    if (b_full_q) begin
      // no input accepted here, drain the spill entry into a
      if (ready_i) begin
        a_load_spill = 1'b1;
        b_full_d     = 1'b0;
      end
    end else if (!a_full_q || ready_i) begin
      a_full_d  = in_fire;
      a_load_in = in_fire;
    end else if (in_fire) begin
      b_load   = 1'b1;
      b_full_d = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_load_in) begin
      a_data_q <= data_i;
    end else if (a_load_spill) begin
      a_data_q <= b_data_q;
    end
    if (b_load) begin
      b_data_q <= data_i;
    end
  end

endmodule

/* design/cluster_addr_decode.sv */
// address decoder: cuts one initiator beat and steers it to TCDM, peripherals or external bus
module cluster_addr_decode #(
  parameter int unsigned ID_IN_WIDTH = 4
) (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic [cluster_bus_pkg::CLUSTER_ID_WIDTH-1:0] cluster_id_i,
  input  logic                                        valid_i,
  output logic                                        ready_o,
  input  logic [cluster_bus_pkg::ADDR_WIDTH-1:0]       addr_i,
  input  logic [ID_IN_WIDTH-1:0]                      id_i,
  input  logic [cluster_bus_pkg::LEN_WIDTH-1:0]        len_i,
  output logic [cluster_bus_pkg::NB_TARGETS-1:0]       tgt_valid_o,
  input  logic [cluster_bus_pkg::NB_TARGETS-1:0]       tgt_ready_i,
  output logic [cluster_bus_pkg::ADDR_WIDTH-1:0]       addr_o,
  output logic [ID_IN_WIDTH-1:0]                      id_o,
  output logic [cluster_bus_pkg::LEN_WIDTH-1:0]        len_o,
  output logic                                        decerr_o,
  output logic [ID_IN_WIDTH-1:0]                      decerr_id_o
);

  typedef logic [cluster_bus_pkg::ADDR_WIDTH-1:0] addr_t;

  typedef struct packed {
    addr_t                                addr;
    logic [ID_IN_WIDTH-1:0]               id;
    logic [cluster_bus_pkg::LEN_WIDTH-1:0] len;
  } in_beat_t;

  in_beat_t                  in_beat, beat;
  logic                      beat_valid, beat_ready;
  addr_t                     cluster_base, offset;
  logic                      in_cluster, hit;
  cluster_bus_pkg::tgt_idx_e tgt_sel;

  assign in_beat = '{addr: addr_i, id: id_i, len: len_i};

  cluster_ax_slice #(
    .payload_t ( in_beat_t )
  ) i_in_slice (
    .clk_i    ( clk_i      ),
    .arst_n_i ( arst_n_i   ),
    .valid_i  ( valid_i    ),
    .ready_o  ( ready_o    ),
    .data_i   ( in_beat    ),
    .valid_o  ( beat_valid ),
    .ready_i  ( beat_ready ),
    .data_o   ( beat       )
  );

  // base never wraps, even base + 4 MiB stays below 2^32 for cluster 63
  assign cluster_base = cluster_bus_pkg::CLUSTER_ADDR_ORIGIN +
                        (addr_t'(cluster_id_i) << cluster_bus_pkg::CLUSTER_ADDR_STRIDE_LOG2);
  assign offset       = beat.addr - cluster_base;
  assign in_cluster   = (beat.addr >= cluster_base) &&
                        (offset < cluster_bus_pkg::PERIPH_END_OFFSET);

  always_comb begin
    tgt_sel = cluster_bus_pkg::TGT_EXT;
    hit     = 1'b1;
    if (in_cluster) begin
      if (offset < cluster_bus_pkg::TCDM_SIZE) begin
        tgt_sel = cluster_bus_pkg::TGT_TCDM;
      end else if (offset >= cluster_bus_pkg::PERIPH_OFFSET) begin
        tgt_sel = cluster_bus_pkg::TGT_PERIPH;
      end else begin
        // hole between TCDM and peripherals
        hit = 1'b0;
      end
    end
  end

  always_comb begin
    for (int i = 0; i < cluster_bus_pkg::NB_TARGETS; i++) begin
      tgt_valid_o[i] = beat_valid && hit && (int'(tgt_sel) == i);
    end
  end

  // an unmapped beat is dropped right away
  assign beat_ready  = hit ? tgt_ready_i[tgt_sel] : 1'b1;
  assign decerr_o    = beat_valid & ~hit;
  assign decerr_id_o = beat.id;

  assign addr_o = beat.addr;
  assign id_o   = beat.id;
  assign len_o  = beat.len;

endmodule

/* design/cluster_bus_mux.sv */
// target multiplexer: round-robin between the two decoders, ID widening and output cut
module cluster_bus_mux #(
  parameter int unsigned ID_IN_WIDTH = 4
) (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,
  input  logic [1:0]                            in_valid_i,
  output logic [1:0]                            in_ready_o,
  input  logic [cluster_bus_pkg::ADDR_WIDTH-1:0] in0_addr_i,
  input  logic [ID_IN_WIDTH-1:0]                in0_id_i,
  input  logic [cluster_bus_pkg::LEN_WIDTH-1:0]  in0_len_i,
  input  logic [cluster_bus_pkg::ADDR_WIDTH-1:0] in1_addr_i,
  input  logic [ID_IN_WIDTH-1:0]                in1_id_i,
  input  logic [cluster_bus_pkg::LEN_WIDTH-1:0]  in1_len_i,
  output logic                                  valid_o,
  input  logic                                  ready_i,
  output logic [cluster_bus_pkg::ADDR_WIDTH-1:0] addr_o,
  output logic [ID_IN_WIDTH:0]                  id_o,
  output logic [cluster_bus_pkg::LEN_WIDTH-1:0]  len_o
);

  // one extra ID bit carries the initiator port index
  localparam int unsigned ID_OUT_WIDTH = ID_IN_WIDTH + 1;

  typedef struct packed {
    logic [cluster_bus_pkg::ADDR_WIDTH-1:0] addr;
    logic [ID_OUT_WIDTH-1:0]               id;
    logic [cluster_bus_pkg::LEN_WIDTH-1:0]  len;
  } out_beat_t;

  logic      rr_q;
  logic      gnt_idx;
  logic      any_req;
  logic      out_ready;
  logic      grant;
  out_beat_t gnt_beat, out_beat;

  assign any_req = |in_valid_i;
  // the pointer port wins if it requests, otherwise the other one
  assign gnt_idx = in_valid_i[rr_q] ? rr_q : ~rr_q;
  // no grant unless the output cut has room
  assign grant   = any_req & out_ready;

  assign in_ready_o[0] = grant & ~gnt_idx;
  assign in_ready_o[1] = grant &  gnt_idx;

  always_comb begin
    if (gnt_idx) begin
      gnt_beat = '{addr: in1_addr_i, id: {1'b1, in1_id_i}, len: in1_len_i};
    end else begin
      gnt_beat = '{addr: in0_addr_i, id: {1'b0, in0_id_i}, len: in0_len_i};
    end
  end

  // after a grant the other port gets priority
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q <= 1'b0;
    end else if (grant) begin
      rr_q <= ~gnt_idx;
    end
  end

  cluster_ax_slice #(
    .payload_t ( out_beat_t )
  ) i_out_slice (
    .clk_i    ( clk_i     ),
    .arst_n_i ( arst_n_i  ),
    .valid_i  ( any_req   ),
    .ready_o  ( out_ready ),
    .data_i   ( gnt_beat  ),
    .valid_o  ( valid_o   ),
    .ready_i  ( ready_i   ),
    .data_o   ( out_beat  )
  );

  assign addr_o = out_beat.addr;
  assign id_o   = out_beat.id;
  assign len_o  = out_beat.len;

endmodule

/* design/cluster_bus_top.sv */
// cluster bus AX router: two initiator decoders feeding three per-target multiplexers
module cluster_bus_top #(
  parameter int unsigned ID_IN_WIDTH = 4
) (
  input  logic                                        clk_i,
  input  logic                                        arst_n_i,
  input  logic [cluster_bus_pkg::CLUSTER_ID_WIDTH-1:0] cluster_id_i,
  // initiator port 0, external and data side
  input  logic                                        p0_valid_i,
  output logic                                        p0_ready_o,
  input  logic [cluster_bus_pkg::ADDR_WIDTH-1:0]       p0_addr_i,
  input  logic [ID_IN_WIDTH-1:0]                      p0_id_i,
  input  logic [cluster_bus_pkg::LEN_WIDTH-1:0]        p0_len_i,
  output logic                                        p0_decerr_o,
  output logic [ID_IN_WIDTH-1:0]                      p0_decerr_id_o,
  // initiator port 1, DMA side
  input  logic                                        p1_valid_i,
  output logic                                        p1_ready_o,
  input  logic [cluster_bus_pkg::ADDR_WIDTH-1:0]       p1_addr_i,
  input  logic [ID_IN_WIDTH-1:0]                      p1_id_i,
  input  logic [cluster_bus_pkg::LEN_WIDTH-1:0]        p1_len_i,
  output logic                                        p1_decerr_o,
  output logic [ID_IN_WIDTH-1:0]                      p1_decerr_id_o,
  // target ports
  output logic                                        tcdm_valid_o,
  input  logic                                        tcdm_ready_i,
  output logic [cluster_bus_pkg::ADDR_WIDTH-1:0]       tcdm_addr_o,
  output logic [ID_IN_WIDTH:0]                        tcdm_id_o,
  output logic [cluster_bus_pkg::LEN_WIDTH-1:0]        tcdm_len_o,
  output logic                                        periph_valid_o,
  input  logic                                        periph_ready_i,
  output logic [cluster_bus_pkg::ADDR_WIDTH-1:0]       periph_addr_o,
  output logic [ID_IN_WIDTH:0]                        periph_id_o,
  output logic [cluster_bus_pkg::LEN_WIDTH-1:0]        periph_len_o,
  output logic                                        ext_valid_o,
  input  logic                                        ext_ready_i,
  output logic [cluster_bus_pkg::ADDR_WIDTH-1:0]       ext_addr_o,
  output logic [ID_IN_WIDTH:0]                        ext_id_o,
  output logic [cluster_bus_pkg::LEN_WIDTH-1:0]        ext_len_o
);

  logic [cluster_bus_pkg::NB_TARGETS-1:0] p0_tgt_valid, p0_tgt_ready;
  logic [cluster_bus_pkg::NB_TARGETS-1:0] p1_tgt_valid, p1_tgt_ready;
  logic [cluster_bus_pkg::ADDR_WIDTH-1:0] p0_dec_addr, p1_dec_addr;
  logic [ID_IN_WIDTH-1:0]                p0_dec_id, p1_dec_id;
  logic [cluster_bus_pkg::LEN_WIDTH-1:0]  p0_dec_len, p1_dec_len;
  logic [1:0]                            tcdm_in_ready, periph_in_ready, ext_in_ready;

  // bit order follows tgt_idx_e, the mux ready index is the initiator port
  assign p0_tgt_ready = {ext_in_ready[0], periph_in_ready[0], tcdm_in_ready[0]};
  assign p1_tgt_ready = {ext_in_ready[1], periph_in_ready[1], tcdm_in_ready[1]};

  cluster_addr_decode #(
    .ID_IN_WIDTH ( ID_IN_WIDTH )
  ) i_p0_decode (
    .clk_i, .arst_n_i, .cluster_id_i,
    .valid_i     ( p0_valid_i     ),
    .ready_o     ( p0_ready_o     ),
    .addr_i      ( p0_addr_i      ),
    .id_i        ( p0_id_i        ),
    .len_i       ( p0_len_i       ),
    .tgt_valid_o ( p0_tgt_valid   ),
    .tgt_ready_i ( p0_tgt_ready   ),
    .addr_o      ( p0_dec_addr    ),
    .id_o        ( p0_dec_id      ),
    .len_o       ( p0_dec_len     ),
    .decerr_o    ( p0_decerr_o    ),
    .decerr_id_o ( p0_decerr_id_o )
  );

  cluster_addr_decode #(
    .ID_IN_WIDTH ( ID_IN_WIDTH )
  ) i_p1_decode (
    .clk_i, .arst_n_i, .cluster_id_i,
    .valid_i     ( p1_valid_i     ),
    .ready_o     ( p1_ready_o     ),
    .addr_i      ( p1_addr_i      ),
    .id_i        ( p1_id_i        ),
    .len_i       ( p1_len_i       ),
    .tgt_valid_o ( p1_tgt_valid   ),
    .tgt_ready_i ( p1_tgt_ready   ),
    .addr_o      ( p1_dec_addr    ),
    .id_o        ( p1_dec_id      ),
    .len_o       ( p1_dec_len     ),
    .decerr_o    ( p1_decerr_o    ),
    .decerr_id_o ( p1_decerr_id_o )
  );

  cluster_bus_mux #(
    .ID_IN_WIDTH ( ID_IN_WIDTH )
  ) i_tcdm_mux (
    .clk_i, .arst_n_i,
    .in_valid_i ( {p1_tgt_valid[cluster_bus_pkg::TGT_TCDM],
                   p0_tgt_valid[cluster_bus_pkg::TGT_TCDM]} ),
    .in_ready_o ( tcdm_in_ready ),
    .in0_addr_i ( p0_dec_addr ), .in0_id_i ( p0_dec_id ), .in0_len_i ( p0_dec_len ),
    .in1_addr_i ( p1_dec_addr ), .in1_id_i ( p1_dec_id ), .in1_len_i ( p1_dec_len ),
    .valid_o    ( tcdm_valid_o ),
    .ready_i    ( tcdm_ready_i ),
    .addr_o     ( tcdm_addr_o  ),
    .id_o       ( tcdm_id_o    ),
    .len_o      ( tcdm_len_o   )
  );

  cluster_bus_mux #(
    .ID_IN_WIDTH ( ID_IN_WIDTH )
  ) i_periph_mux (
    .clk_i, .arst_n_i,
    .in_valid_i ( {p1_tgt_valid[cluster_bus_pkg::TGT_PERIPH],
                   p0_tgt_valid[cluster_bus_pkg::TGT_PERIPH]} ),
    .in_ready_o ( periph_in_ready ),
    .in0_addr_i ( p0_dec_addr ), .in0_id_i ( p0_dec_id ), .in0_len_i ( p0_dec_len ),
    .in1_addr_i ( p1_dec_addr ), .in1_id_i ( p1_dec_id ), .in1_len_i ( p1_dec_len ),
    .valid_o    ( periph_valid_o ),
    .ready_i    ( periph_ready_i ),
    .addr_o     ( periph_addr_o  ),
    .id_o       ( periph_id_o    ),
    .len_o      ( periph_len_o   )
  );

  cluster_bus_mux #(
    .ID_IN_WIDTH ( ID_IN_WIDTH )
  ) i_ext_mux (
    .clk_i, .arst_n_i,
    .in_valid_i ( {p1_tgt_valid[cluster_bus_pkg::TGT_EXT],
                   p0_tgt_valid[cluster_bus_pkg::TGT_EXT]} ),
    .in_ready_o ( ext_in_ready ),
    .in0_addr_i ( p0_dec_addr ), .in0_id_i ( p0_dec_id ), .in0_len_i ( p0_dec_len ),
    .in1_addr_i ( p1_dec_addr ), .in1_id_i ( p1_dec_id ), .in1_len_i ( p1_dec_len ),
    .valid_o    ( ext_valid_o ),
    .ready_i    ( ext_ready_i ),
    .addr_o     ( ext_addr_o  ),
    .id_o       ( ext_id_o    ),
    .len_o      ( ext_len_o   )
  );

endmodule

/* tb/tb_cluster_bus.sv */
// cluster bus AX router testbench driving file patterns and scoring every routed beat
module tb_cluster_bus;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int ID_W = 4;

  logic            clk_i = 1'b0;
  logic            arst_n_i;
  logic [5:0]      cluster_id_i;
  logic            p0_valid_i, p0_ready_o, p0_decerr_o;
  logic [31:0]     p0_addr_i;
  logic [ID_W-1:0] p0_id_i, p0_decerr_id_o;
  logic [7:0]      p0_len_i;
  logic            p1_valid_i, p1_ready_o, p1_decerr_o;
  logic [31:0]     p1_addr_i;
  logic [ID_W-1:0] p1_id_i, p1_decerr_id_o;
  logic [7:0]      p1_len_i;
  logic            tcdm_valid_o, tcdm_ready_i, periph_valid_o, periph_ready_i;
  logic            ext_valid_o, ext_ready_i;
  logic [31:0]     tcdm_addr_o, periph_addr_o, ext_addr_o;
  logic [ID_W:0]   tcdm_id_o, periph_id_o, ext_id_o;
  logic [7:0]      tcdm_len_o, periph_len_o, ext_len_o;

  // pattern rows, row_tgt holds the target worked out from the address map
  logic [5:0]      row_cid [64];
  int              row_port [64];
  logic [31:0]     row_addr [64];
  logic [ID_W-1:0] row_id [64];
  logic [7:0]      row_len [64];
  int              row_tgt [64];
  int              nrows;

  // expected beats indexed by target * 2 + port, entry is {addr, widened id, len}
  logic [44:0]     exp_q [6][$];
  logic [ID_W-1:0] derr_q [2][$];
  string           tgt_name [3] = '{"tcdm", "periph", "ext"};
  int              last_port [3];
  bit              alt_check = 1'b0;
  bit              bp_on = 1'b0;
  int              cycle_cnt = 0;
  int              cycle_limit = 200;
  int              last_event_cycle = 0;
  int              value_errs = 0;
  int              other_errs = 0;

  cluster_bus_top #(
    .ID_IN_WIDTH ( ID_W )
  ) UUT (.*);

  always #20 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic check_value(input string name, input logic [63:0] actual,
                             input logic [63:0] expected);
    if (actual !== expected) begin
      value_errs++;
      $display("[ERROR] %0t %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  // target from the map rule, 3 marks the unmapped hole
  function automatic int map_target(input logic [5:0] cid, input logic [31:0] addr);
    logic [33:0] base;
    logic [33:0] a;
    base = 34'h1000_0000 + 34'h40_0000 * 34'(cid);
    a    = {2'b00, addr};
    if (a < base || a >= base + 34'h40_0000) return 2;
    if (a < base + 34'h10_0000) return 0;
    if (a >= base + 34'h20_0000) return 1;
    return 3;
  endfunction

  task automatic load_patterns(output int n);
    int          fd;
    string       line;
    int unsigned f_cid, f_port, f_addr, f_id, f_len, f_tgt;
    n  = 0;
    fd = $fopen("tb/cluster_bus_patterns.txt", "r");
    if (fd == 0) begin
      other_errs++;
      $display("cannot open the pattern file tb/cluster_bus_patterns.txt");
      return;
    end
    while ($fgets(line, fd) != 0) begin
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      if (n >= 64 || $sscanf(line, "%h %h %h %h %h %h",
                             f_cid, f_port, f_addr, f_id, f_len, f_tgt) != 6) begin
        other_errs++;
        $display("pattern line could not be read or does not fit: %s", line);
        continue;
      end
      row_cid[n]  = f_cid[5:0];
      row_port[n] = f_port;
      row_addr[n] = f_addr;
      row_id[n]   = f_id[ID_W-1:0];
      row_len[n]  = f_len[7:0];
      row_tgt[n]  = map_target(row_cid[n], row_addr[n]);
      if (row_tgt[n] != int'(f_tgt)) begin
        other_errs++;
        $display("pattern file error on row %0d, file says target %0d but the map gives %0d",
                 n, f_tgt, row_tgt[n]);
      end
      n++;
    end
    $fclose(fd);
  endtask

  function automatic int pending_count();
    int n;
    n = derr_q[0].size() + derr_q[1].size();
    for (int k = 0; k < 6; k++) begin
      n += exp_q[k].size();
    end
    return n;
  endfunction

  task automatic set_port(input int p, input logic valid, input logic [31:0] addr,
                          input logic [ID_W-1:0] id, input logic [7:0] len);
    if (p == 0) begin
      p0_valid_i <= valid;
      p0_addr_i  <= addr;
      p0_id_i    <= id;
      p0_len_i   <= len;
    end else begin
      p1_valid_i <= valid;
      p1_addr_i  <= addr;
      p1_id_i    <= id;
      p1_len_i   <= len;
    end
  endtask

  function automatic logic port_ready(input int p);
    return (p == 0) ? p0_ready_o : p1_ready_o;
  endfunction

  // drives one row and returns at the edge where it transfers
  task automatic issue_beat(input int p, input int r, output int xfer);
    set_port(p, 1'b1, row_addr[r], row_id[r], row_len[r]);
    @(negedge clk_i);
    while (!port_ready(p)) @(negedge clk_i);
    xfer = cycle_cnt;
    if (row_tgt[r] == 3) begin
      derr_q[p].push_back(row_id[r]);
    end else begin
      exp_q[row_tgt[r] * 2 + p].push_back({row_addr[r], p[0], row_id[r], row_len[r]});
    end
    @(posedge clk_i);
  endtask

  task automatic drive_port(input int p, input int first, input int last, input bit stream);
    int gap;
    int xfer;
    for (int r = first; r < last; r++) begin
      if (row_port[r] == p) begin
        gap = stream ? 0 : $urandom % 3;
        if (gap > 0) begin
          set_port(p, 1'b0, 32'h0, '0, 8'h0);
          repeat (gap) @(posedge clk_i);
        end
        issue_beat(p, r, xfer);
      end
    end
    set_port(p, 1'b0, 32'h0, '0, 8'h0);
  endtask

  task automatic wait_idle();
    while (pending_count() != 0) @(posedge clk_i);
  endtask

  // lone first beat for latency, then both ports together
  task automatic run_group(input int first, input int last);
    int xfer;
    bit stream;
    stream = (last - first >= 3);
    for (int r = first + 1; r < last; r++) begin
      if (row_tgt[r] == 3 || row_tgt[r] != row_tgt[first + 1]) stream = 1'b0;
    end
    bp_on = 1'b0;
    wait_idle();
    cluster_id_i <= row_cid[first];
    @(posedge clk_i);
    issue_beat(row_port[first], first, xfer);
    set_port(row_port[first], 1'b0, 32'h0, '0, 8'h0);
    wait_idle();
    check_value("lone beat latency in cycles", 64'(last_event_cycle - xfer),
                (row_tgt[first] == 3) ? 64'd1 : 64'd2);
    // a group that all goes to one target streams with no gaps and full ready
    alt_check = stream;
    last_port = '{2, 2, 2};
    bp_on     = !stream;
    fork
      drive_port(0, first + 1, last, stream);
      drive_port(1, first + 1, last, stream);
    join
    bp_on = 1'b0;
    wait_idle();
    alt_check = 1'b0;
  endtask

  task automatic take_output(input int t, input logic [31:0] addr, input logic [ID_W:0] id,
                             input logic [7:0] len);
    int          p;
    logic [44:0] e;
    p = id[ID_W] ? 1 : 0;
    if (exp_q[t * 2 + p].size() == 0) begin
      other_errs++;
      $display("%0t beat at %s from port %0d with nothing outstanding", $time, tgt_name[t], p);
    end else begin
      e = exp_q[t * 2 + p].pop_front();
      check_value({tgt_name[t], "_addr_o"}, 64'(addr), 64'(e[44:13]));
      check_value({tgt_name[t], "_id_o"}, 64'(id), 64'(e[12:8]));
      check_value({tgt_name[t], "_len_o"}, 64'(len), 64'(e[7:0]));
    end
    if (alt_check && last_port[t] < 2) begin
      check_value({tgt_name[t], "_id_o port bit"}, 64'(p), 64'(1 - last_port[t]));
    end
    last_port[t]     = p;
    last_event_cycle = cycle_cnt;
  endtask

  task automatic take_decerr(input int p, input logic [ID_W-1:0] id);
    if (derr_q[p].size() == 0) begin
      other_errs++;
      $display("%0t decode error pulse on port %0d with no unmapped beat outstanding", $time, p);
    end else begin
      check_value((p == 0) ? "p0_decerr_id_o" : "p1_decerr_id_o",
                  64'(id), 64'(derr_q[p].pop_front()));
    end
    last_event_cycle = cycle_cnt;
  endtask

  task automatic finish_run();
    if (pending_count() != 0) begin
      other_errs++;
      $display("run ended with %0d beats or decode errors never seen", pending_count());
    end
    $display("closing report %0d value errors and %0d other errors", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  endtask

  // target ready, random while back-pressure is on
  initial begin
    tcdm_ready_i   <= 1'b1;
    periph_ready_i <= 1'b1;
    ext_ready_i    <= 1'b1;
    forever begin
      @(posedge clk_i);
      tcdm_ready_i   <= bp_on ? (($urandom % 4) != 0) : 1'b1;
      periph_ready_i <= bp_on ? (($urandom % 4) != 0) : 1'b1;
      ext_ready_i    <= bp_on ? (($urandom % 4) != 0) : 1'b1;
    end
  end

  // scoreboard and cycle limit, sampled mid-cycle so the next edge's transfers are known
  initial begin
    forever begin
      @(negedge clk_i);
      if (arst_n_i) begin
        if (tcdm_valid_o && tcdm_ready_i) take_output(0, tcdm_addr_o, tcdm_id_o, tcdm_len_o);
        if (periph_valid_o && periph_ready_i) begin
          take_output(1, periph_addr_o, periph_id_o, periph_len_o);
        end
        if (ext_valid_o && ext_ready_i) take_output(2, ext_addr_o, ext_id_o, ext_len_o);
        if (p0_decerr_o) take_decerr(0, p0_decerr_id_o);
        if (p1_decerr_o) take_decerr(1, p1_decerr_id_o);
      end
      if (cycle_cnt >= cycle_limit) begin
        other_errs++;
        $display("timeout after %0d cycles, the bus stopped delivering beats", cycle_cnt);
        finish_run();
      end
    end
  end

  initial begin
    int first;
    int last;
    void'($urandom(32'h27ef_2828));
    $timeformat(-9, 1, " ns", 0);
    arst_n_i     <= 1'b0;
    cluster_id_i <= 6'd0;
    set_port(0, 1'b0, 32'h0, '0, 8'h0);
    set_port(1, 1'b0, 32'h0, '0, 8'h0);
    load_patterns(nrows);
    cycle_limit = 200 + 40 * nrows;
    repeat (8) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(posedge clk_i);
    @(negedge clk_i);
    // idle state out of reset
    check_value("tcdm_valid_o", 64'(tcdm_valid_o), 64'd0);
    check_value("periph_valid_o", 64'(periph_valid_o), 64'd0);
    check_value("ext_valid_o", 64'(ext_valid_o), 64'd0);
    check_value("p0_decerr_o", 64'(p0_decerr_o), 64'd0);
    check_value("p1_decerr_o", 64'(p1_decerr_o), 64'd0);
    check_value("p0_ready_o", 64'(p0_ready_o), 64'd1);
    check_value("p1_ready_o", 64'(p1_ready_o), 64'd1);
    @(posedge clk_i);
    // rows sharing a cluster identifier form one group
    first = 0;
    while (first < nrows) begin
      last = first + 1;
      while (last < nrows && row_cid[last] == row_cid[first]) last++;
      run_group(first, last);
      first = last;
    end
    finish_run();
  end

endmodule

/* tb/cluster_bus_patterns.txt */
# columns are cluster_id port address id len target, all in hex
# target 0 tcdm, 1 periph, 2 ext, 3 decode error
# cluster 0, region edges and the hole under random back-pressure
00 0 10000000 3 00 0
00 1 100ffffc 5 07 0
00 0 10200000 1 0f 1
00 1 103ffffc 2 01 1
00 0 0ffffffc 4 03 2
00 1 10400000 6 ff 2
00 0 00000000 7 00 2
00 1 fffffffc 8 02 2
00 0 10100000 9 00 3
00 1 101ffffc a 01 3
00 0 10000040 b 10 0
00 1 10000080 c 11 0
00 0 100000c0 d 12 0
00 1 10000100 e 13 0
# cluster 5, both ports stream into tcdm
05 1 11400000 1 00 0
05 0 11400010 0 01 0
05 1 11400020 1 02 0
05 0 11400030 2 03 0
05 1 11400040 3 04 0
05 0 114ffffc 4 05 0
05 1 11400060 5 06 0
# cluster 1, the map moves up by one stride
01 0 10000000 2 00 2
01 1 10400000 3 01 0
01 0 104ffffc 4 02 0
01 1 10500000 5 00 3
01 0 10600000 6 03 1
01 1 10800000 7 04 2
01 0 1023fffc 8 05 2

/* tb.f */
design/cluster_bus_pkg.sv
design/cluster_ax_slice.sv
design/cluster_addr_decode.sv
design/cluster_bus_mux.sv
design/cluster_bus_top.sv
tb/tb_cluster_bus.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_cluster_bus
FILELIST  = tb.f

.PHONY: sim clean

# build, run, and pass only if the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
